// File: hw/hbmc_pkg.sv
// shared types for the AXI4 front end; 32-bit beats only, 4-bit ids, 8 MiB power-of-two window
`default_nettype none

package hbmc_pkg;

    localparam int AXI_ID_W   = 4;
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = 4;
    localparam int HB_WORD_W  = 16;
    localparam int HB_STRB_W  = 2;

    localparam logic [AXI_ADDR_W-1:0] MEM_SIZE_BYTES = 32'h0080_0000; // must be a power of two

    localparam int WBUF_DEPTH = 16;                   // beats, also the max write burst
    localparam int RBUF_DEPTH = 4;
    localparam int WBUF_AW    = $clog2(WBUF_DEPTH);
    localparam int RBUF_AW    = $clog2(RBUF_DEPTH);

    localparam logic [1:0] AXI_BURST_WRAP = 2'b10;
    localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;
        logic [1:0]            burst;
    } axi_addr_t;

    typedef struct packed {
        logic [31:0] mem_addr;       // halfword address
        logic [15:0] word_count;     // halfwords
        logic        wr_not_rd;
        logic        wrap_not_incr;
    } hb_cmd_t;

    typedef struct packed {
        logic [HB_WORD_W-1:0] data;
        logic [HB_STRB_W-1:0] strb;
    } hb_wr_word_t;

    typedef struct packed {
        logic [HB_WORD_W-1:0] data;
        logic                 last;
    } hb_rd_word_t;

endpackage

`default_nettype wire

// File: hw/xfer_arbiter.sv
// one transfer in flight at a time; a write is only taken once its whole burst is buffered
`timescale 1ns/1ns
`default_nettype none

module xfer_arbiter import hbmc_pkg::*; (
    input  wire logic          s_axi_aclk,
    input  wire logic          s_axi_aresetn,
    input  wire axi_addr_t     aw_req,
    input  wire logic          awvalid,
    input  wire axi_addr_t     ar_req,
    input  wire logic          arvalid,
    input  wire logic          wr_pending,
    input  wire logic          wr_done,
    input  wire logic          rd_done,
    input  wire logic          hb_cmd_ready,
    output logic               awready,
    output logic               arready,
    output logic               aw_taken,
    output logic [AXI_ID_W-1:0] xfer_id,
    output hb_cmd_t            hb_cmd,
    output logic               hb_cmd_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT
    } state_t;

    state_t state;
    logic   wr_req;
    logic   rd_req;
    logic   pick_wr;
    logic   done_pulse;
    logic   done_seen;  // completion that arrived before the cmd handshake

    function automatic hb_cmd_t form_cmd(input axi_addr_t req, input logic wr);
        hb_cmd_t               cmd;
        logic [AXI_ADDR_W-1:0] masked;
        masked            = req.addr & (MEM_SIZE_BYTES - 1'b1);
        masked[1:0]       = 2'b00;                       // beat aligned
        cmd.mem_addr      = masked >> 1;                 // bytes to halfwords
        cmd.word_count    = ({8'd0, req.len} + 16'd1) << 1;
        cmd.wr_not_rd     = wr;
        cmd.wrap_not_incr = (req.burst == AXI_BURST_WRAP);
        return cmd;
    endfunction

    assign wr_req     = awvalid && wr_pending;
    assign rd_req     = arvalid;
    assign pick_wr    = wr_req && (!rd_req || !hb_cmd.wr_not_rd); // tie goes opposite to last
    assign aw_taken   = awvalid && awready;
    assign done_pulse = hb_cmd.wr_not_rd ? wr_done : rd_done;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state        <= ST_IDLE;
            awready      <= 1'b0;
            arready      <= 1'b0;
            hb_cmd_valid <= 1'b0;
            hb_cmd       <= '0;      // wr_not_rd = 0 so the first tie picks the write
            xfer_id      <= '0;
            done_seen    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    done_seen <= 1'b0;
                    if (pick_wr) begin
                        awready <= 1'b1;
                        xfer_id <= aw_req.id;
                        hb_cmd  <= form_cmd(aw_req, 1'b1);
                        state   <= ST_ISSUE;
                    end else if (rd_req) begin
                        arready <= 1'b1;
                        xfer_id <= ar_req.id;
                        hb_cmd  <= form_cmd(ar_req, 1'b0);
                        state   <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (done_pulse) begin
                        done_seen <= 1'b1;   // B can finish before the memory takes the cmd
                    end
                    if (awready || arready) begin
                        awready      <= 1'b0; // address handshake completes this cycle
                        arready      <= 1'b0;
                        hb_cmd_valid <= 1'b1;
                    end else if (hb_cmd_ready) begin
                        hb_cmd_valid <= 1'b0;
                        state        <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (done_pulse || done_seen) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/wr_resp_tracker.sv
// B response is sent once address and data are both in; memory write may still be in progress
`timescale 1ns/1ns
`default_nettype none

module wr_resp_tracker import hbmc_pkg::*; (
    input  wire logic                s_axi_aclk,
    input  wire logic                s_axi_aresetn,
    input  wire logic                aw_taken,
    input  wire logic                wr_burst_in,
    input  wire logic                bready,
    input  wire logic [AXI_ID_W-1:0] xfer_id,
    output logic                     bvalid,
    output logic [AXI_ID_W-1:0]      bid,
    output logic [1:0]               bresp,
    output logic                     wr_pending,
    output logic                     wr_done
);

    logic [WBUF_AW:0] burst_cnt;  // complete bursts buffered, not yet answered
    logic             addr_seen;
    logic             b_hs;

    assign b_hs       = bvalid && bready;
    assign wr_done    = b_hs;
    assign wr_pending = (burst_cnt != '0);
    assign bid        = xfer_id;
    assign bresp      = AXI_RESP_OKAY;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            burst_cnt <= '0;
            addr_seen <= 1'b0;
            bvalid    <= 1'b0;
        end else begin
            case ({wr_burst_in, b_hs})
                2'b10:   burst_cnt <= burst_cnt + 1'b1;
                2'b01:   burst_cnt <= burst_cnt - 1'b1;
                default: burst_cnt <= burst_cnt;
            endcase
            if (b_hs) begin
                addr_seen <= 1'b0;
                bvalid    <= 1'b0;
            end else begin
                if (aw_taken) begin
                    addr_seen <= 1'b1;
                end
                if ((addr_seen || aw_taken) && (wr_pending || wr_burst_in)) begin
                    bvalid <= 1'b1;  // either order of arrival
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/wdata_splitter.sv
// write beat FIFO of 16 entries; each beat leaves as low halfword then high halfword
`timescale 1ns/1ns
`default_nettype none

module wdata_splitter import hbmc_pkg::*; (
    input  wire logic                  s_axi_aclk,
    input  wire logic                  s_axi_aresetn,
    input  wire logic [AXI_DATA_W-1:0] wdata,
    input  wire logic [AXI_STRB_W-1:0] wstrb,
    input  wire logic                  wlast,
    input  wire logic                  wvalid,
    input  wire logic                  hb_wr_ready,
    output logic                       wready,
    output logic                       wr_burst_in,
    output hb_wr_word_t                hb_wr_word,
    output logic                       hb_wr_valid
);

    logic [AXI_DATA_W+AXI_STRB_W-1:0] beat_mem [WBUF_DEPTH];
    logic [WBUF_AW:0]                 wr_ptr;     // msb is the lap bit
    logic [WBUF_AW:0]                 rd_ptr;
    logic                             half_hi;
    logic                             full;
    logic                             empty;
    logic                             push;
    logic                             word_hs;
    logic [AXI_DATA_W-1:0]            head_data;
    logic [AXI_STRB_W-1:0]            head_strb;

    assign full  = (wr_ptr[WBUF_AW] != rd_ptr[WBUF_AW])
                && (wr_ptr[WBUF_AW-1:0] == rd_ptr[WBUF_AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign wready      = !full;
    assign push        = wvalid && wready;
    assign wr_burst_in = push && wlast;

    assign {head_data, head_strb} = beat_mem[rd_ptr[WBUF_AW-1:0]];

    assign hb_wr_valid     = !empty;
    assign hb_wr_word.data = half_hi ? head_data[AXI_DATA_W-1:HB_WORD_W] : head_data[HB_WORD_W-1:0];
    assign hb_wr_word.strb = half_hi ? head_strb[AXI_STRB_W-1:HB_STRB_W] : head_strb[HB_STRB_W-1:0];
    assign word_hs         = hb_wr_valid && hb_wr_ready;

    always_ff @(posedge s_axi_aclk) begin
        if (push) begin
            beat_mem[wr_ptr[WBUF_AW-1:0]] <= {wdata, wstrb};
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            half_hi <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (word_hs) begin
                half_hi <= !half_hi;
                if (half_hi) begin
                    rd_ptr <= rd_ptr + 1'b1; // both halves sent, drop the beat
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rdata_assembler.sv
// read words must arrive in pairs, low half first; last is taken from the second word only
`timescale 1ns/1ns
`default_nettype none

module rdata_assembler import hbmc_pkg::*; (
    input  wire logic                s_axi_aclk,
    input  wire logic                s_axi_aresetn,
    input  wire hb_rd_word_t         hb_rd_word,
    input  wire logic                hb_rd_valid,
    input  wire logic                rready,
    input  wire logic [AXI_ID_W-1:0] xfer_id,
    output logic                     hb_rd_ready,
    output logic [AXI_DATA_W-1:0]    rdata,
    output logic                     rlast,
    output logic                     rvalid,
    output logic [AXI_ID_W-1:0]      rid,
    output logic [1:0]               rresp
);

    logic [AXI_DATA_W:0]  beat_mem [RBUF_DEPTH];  // {last, data}
    logic [RBUF_AW:0]     wr_ptr;
    logic [RBUF_AW:0]     rd_ptr;
    logic [HB_WORD_W-1:0] lo_word;
    logic                 have_lo;
    logic                 full;
    logic                 empty;
    logic                 word_hs;
    logic                 push;
    logic                 pop;

    assign full  = (wr_ptr[RBUF_AW] != rd_ptr[RBUF_AW])
                && (wr_ptr[RBUF_AW-1:0] == rd_ptr[RBUF_AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign hb_rd_ready = !full;
    assign word_hs     = hb_rd_valid && hb_rd_ready;
    assign push        = word_hs && have_lo;     // second half completes the beat
    assign pop         = rvalid && rready;

    assign {rlast, rdata} = beat_mem[rd_ptr[RBUF_AW-1:0]];
    assign rvalid         = !empty;
    assign rid            = xfer_id;
    assign rresp          = AXI_RESP_OKAY;

    always_ff @(posedge s_axi_aclk) begin
        if (word_hs && !have_lo) begin
            lo_word <= hb_rd_word.data;
        end
        if (push) begin
            beat_mem[wr_ptr[RBUF_AW-1:0]] <= {hb_rd_word.last, hb_rd_word.data, lo_word};
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            have_lo <= 1'b0;
        end else begin
            if (word_hs) begin
                have_lo <= !have_lo;
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/axi_hbmc_top.sv
// AXI4 slave front end; awsize/arsize ignored, FIXED treated as INCR, writes up to 16 beats
`timescale 1ns/1ns
`default_nettype none

module axi_hbmc_top import hbmc_pkg::*; (
    input  wire logic                  s_axi_aclk,
    input  wire logic                  s_axi_aresetn,

    input  wire axi_addr_t             aw_req,
    input  wire logic                  awvalid,
    output logic                       awready,

    input  wire logic [AXI_DATA_W-1:0] wdata,
    input  wire logic [AXI_STRB_W-1:0] wstrb,
    input  wire logic                  wlast,
    input  wire logic                  wvalid,
    output logic                       wready,

    output logic [AXI_ID_W-1:0]        bid,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  wire logic                  bready,

    input  wire axi_addr_t             ar_req,
    input  wire logic                  arvalid,
    output logic                       arready,

    output logic [AXI_ID_W-1:0]        rid,
    output logic [AXI_DATA_W-1:0]      rdata,
    output logic [1:0]                 rresp,
    output logic                       rlast,
    output logic                       rvalid,
    input  wire logic                  rready,

    output hb_cmd_t                    hb_cmd,
    output logic                       hb_cmd_valid,
    input  wire logic                  hb_cmd_ready,

    output hb_wr_word_t                hb_wr_word,
    output logic                       hb_wr_valid,
    input  wire logic                  hb_wr_ready,

    input  wire hb_rd_word_t           hb_rd_word,
    input  wire logic                  hb_rd_valid,
    output logic                       hb_rd_ready
);

    logic                wr_burst_in;
    logic                wr_pending;
    logic                wr_done;
    logic                rd_done;
    logic                aw_taken;
    logic [AXI_ID_W-1:0] xfer_id;

    assign rd_done = rvalid && rready && rlast; // final R beat accepted

    xfer_arbiter arb_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .aw_req        (aw_req),
        .awvalid       (awvalid),
        .ar_req        (ar_req),
        .arvalid       (arvalid),
        .wr_pending    (wr_pending),
        .wr_done       (wr_done),
        .rd_done       (rd_done),
        .hb_cmd_ready  (hb_cmd_ready),
        .awready       (awready),
        .arready       (arready),
        .aw_taken      (aw_taken),
        .xfer_id       (xfer_id),
        .hb_cmd        (hb_cmd),
        .hb_cmd_valid  (hb_cmd_valid)
    );

    wr_resp_tracker bresp_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .aw_taken      (aw_taken),
        .wr_burst_in   (wr_burst_in),
        .bready        (bready),
        .xfer_id       (xfer_id),
        .bvalid        (bvalid),
        .bid           (bid),
        .bresp         (bresp),
        .wr_pending    (wr_pending),
        .wr_done       (wr_done)
    );

    wdata_splitter wbuf_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wlast         (wlast),
        .wvalid        (wvalid),
        .hb_wr_ready   (hb_wr_ready),
        .wready        (wready),
        .wr_burst_in   (wr_burst_in),
        .hb_wr_word    (hb_wr_word),
        .hb_wr_valid   (hb_wr_valid)
    );

    rdata_assembler rbuf_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .hb_rd_word    (hb_rd_word),
        .hb_rd_valid   (hb_rd_valid),
        .rready        (rready),
        .xfer_id       (xfer_id),
        .hb_rd_ready   (hb_rd_ready),
        .rdata         (rdata),
        .rlast         (rlast),
        .rvalid        (rvalid),
        .rid           (rid),
        .rresp         (rresp)
    );

endmodule

`default_nettype wire

// File: verif/hb_mem_model.sv
// behavioral memory of 4096 halfwords; higher address bits alias, commands are served one at a time
`timescale 1ns/1ns
`default_nettype none

module hb_mem_model import hbmc_pkg::*; (
    input  wire logic        s_axi_aclk,
    input  wire logic        s_axi_aresetn,
    input  wire hb_cmd_t     hb_cmd,
    input  wire logic        hb_cmd_valid,
    output logic             hb_cmd_ready,
    input  wire hb_wr_word_t hb_wr_word,
    input  wire logic        hb_wr_valid,
    output logic             hb_wr_ready,
    output hb_rd_word_t      hb_rd_word,
    output logic             hb_rd_valid,
    input  wire logic        hb_rd_ready
);

    localparam int MODEL_AW = 12;

    logic [HB_WORD_W-1:0] mem [2**MODEL_AW];
    hb_cmd_t              cur;
    logic                 busy;
    logic [15:0]          idx;       // halfword index within the command
    logic [MODEL_AW-1:0]  cur_addr;
    logic                 last_word;

    function automatic logic [MODEL_AW-1:0] word_addr(input hb_cmd_t c, input logic [15:0] i);
        logic [31:0] wmask;
        logic [31:0] a;
        wmask = {16'd0, c.word_count} - 32'd1;
        if (c.wrap_not_incr) begin
            a = (c.mem_addr & ~wmask) | ((c.mem_addr + i) & wmask); // stay inside the boundary
        end else begin
            a = c.mem_addr + i;
        end
        return a[MODEL_AW-1:0];
    endfunction

    initial begin
        for (int i = 0; i < 2**MODEL_AW; i++) begin
            mem[i] = 16'(i * 32'h2F1B) ^ 16'hC35A; // pattern over the whole index
        end
    end

    assign cur_addr        = word_addr(cur, idx);
    assign last_word       = (idx == cur.word_count - 16'd1);
    assign hb_cmd_ready    = !busy;
    assign hb_wr_ready     = busy && cur.wr_not_rd;
    assign hb_rd_valid     = busy && !cur.wr_not_rd;
    assign hb_rd_word.data = mem[cur_addr];
    assign hb_rd_word.last = last_word;

    always @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            busy <= 1'b0;
            idx  <= '0;
            cur  <= '0;
        end else begin
            if (hb_cmd_valid && hb_cmd_ready) begin
                cur  <= hb_cmd;
                busy <= 1'b1;
                idx  <= '0;
            end
            if (hb_wr_valid && hb_wr_ready) begin
                if (hb_wr_word.strb[0]) mem[cur_addr][7:0]  <= hb_wr_word.data[7:0];
                if (hb_wr_word.strb[1]) mem[cur_addr][15:8] <= hb_wr_word.data[15:8];
            end
            if ((hb_wr_valid && hb_wr_ready) || (hb_rd_valid && hb_rd_ready)) begin
                idx <= idx + 16'd1;
                if (last_word) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_axi_hbmc.sv
// testbench for the AXI front end; addresses alias into the 4096-halfword model, one id in flight
`timescale 1ns/1ns
`default_nettype none

module tb_axi_hbmc import hbmc_pkg::*; ();

    localparam int TIMEOUT = 2000;
    localparam int REF_AW  = 12;

    logic s_axi_aclk;
    logic s_axi_aresetn;
    axi_addr_t aw_req;
    axi_addr_t ar_req;
    logic awvalid;
    logic awready;
    logic wlast;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    logic arvalid;
    logic arready;
    logic rlast;
    logic rvalid;
    logic rready;
    logic [AXI_DATA_W-1:0] wdata;
    logic [AXI_DATA_W-1:0] rdata;
    logic [AXI_STRB_W-1:0] wstrb;
    logic [AXI_ID_W-1:0] bid;
    logic [AXI_ID_W-1:0] rid;
    logic [1:0] bresp;
    logic [1:0] rresp;
    hb_cmd_t hb_cmd;
    logic hb_cmd_valid;
    logic hb_cmd_ready;
    logic hb_wr_valid;
    logic hb_wr_ready;
    logic hb_rd_valid;
    logic hb_rd_ready;
    hb_wr_word_t hb_wr_word;
    hb_rd_word_t hb_rd_word;

    logic [15:0] ref_mem [2**REF_AW];   // expected memory contents
    hb_cmd_t     exp_q[$];
    logic        kind_q[$];
    int          mismatch_errs;
    int          assert_errs;
    int          timeout_errs;
    string       test_name;

    axi_hbmc_top dut_i (.*);
    hb_mem_model mem_i (.*);

    always #10 s_axi_aclk = ~s_axi_aclk;

    // handshake rules
    assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
        else begin
            assert_errs++;
            $display("B channel changed before its handshake");
        end
    assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast) && $stable(rid))
        else begin
            assert_errs++;
            $display("R channel changed before its handshake");
        end
    assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (!bvalid || bresp == AXI_RESP_OKAY) && (!rvalid || rresp == AXI_RESP_OKAY))
        else begin
            assert_errs++;
            $display("response code is not OKAY");
        end
    assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (awready || arready) |=> !(awready || arready))
        else begin
            assert_errs++;
            $display("address ready held longer than one cycle");
        end

    function automatic hb_cmd_t expect_cmd(input axi_addr_t r, input logic wr);
        hb_cmd_t     c;
        logic [31:0] byte_off;
        byte_off        = r.addr % MEM_SIZE_BYTES;
        c.mem_addr      = (byte_off / 4) * 2;
        c.word_count    = 16'((r.len + 1) * 2);
        c.wr_not_rd     = wr;
        c.wrap_not_incr = (r.burst == 2'b10);
        return c;
    endfunction

    function automatic int half_addr(input logic [31:0] addr, input int len, input logic wrap,
                                     input int j);
        int start;
        int wc;
        int base;
        start = ((addr % MEM_SIZE_BYTES) / 4) * 2;
        wc    = 2 * (len + 1);
        base  = wrap ? start - (start % wc) : start;
        if (wrap) return (base + (start - base + j) % wc) % (2**REF_AW);
        return (start + j) % (2**REF_AW);
    endfunction

    task automatic finish_run();
        $display("errors: mismatch=%0d assertion=%0d timeout=%0d",
                 mismatch_errs, assert_errs, timeout_errs);
        if (mismatch_errs + assert_errs + timeout_errs == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    endtask

    task automatic fail_timeout(input string what);
        timeout_errs++;
        $display("Timeout in %s: %s did not happen within %0d cycles", test_name, what, TIMEOUT);
        finish_run();
    endtask

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            mismatch_errs++;
            $display("Mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // command monitor sees the values from before the edge
    always @(posedge s_axi_aclk) begin
        if (s_axi_aresetn) begin
            if (awvalid && awready) exp_q.push_back(expect_cmd(aw_req, 1'b1));
            if (arvalid && arready) exp_q.push_back(expect_cmd(ar_req, 1'b0));
            if (hb_cmd_valid && hb_cmd_ready) begin
                kind_q.push_back(hb_cmd.wr_not_rd);
                if (exp_q.size() == 0) begin
                    mismatch_errs++;
                    $display("memory command issued without an accepted address");
                end else begin
                    check_val("hb_cmd", 64'(exp_q.pop_front()), 64'(hb_cmd));
                end
            end
        end
    end

    task automatic send_wdata(input logic [31:0] addr, input int len);
        int lo;
        int hi;
        int n;
        for (int k = 0; k <= len; k++) begin
            wdata = $urandom;
            wstrb = $urandom;
            wlast = (k == len);
            wvalid = 1'b1;
            lo = half_addr(addr, len, 1'b0, 2 * k);
            hi = half_addr(addr, len, 1'b0, 2 * k + 1);
            if (wstrb[0]) ref_mem[lo][7:0]  = wdata[7:0];
            if (wstrb[1]) ref_mem[lo][15:8] = wdata[15:8];
            if (wstrb[2]) ref_mem[hi][7:0]  = wdata[23:16];
            if (wstrb[3]) ref_mem[hi][15:8] = wdata[31:24];
            n = 0;
            do begin
                @(posedge s_axi_aclk);
                n++;
                if (n > TIMEOUT) fail_timeout("W beat acceptance");
            end while (!wready);
            #2;
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
    endtask

    task automatic send_awb(input logic [3:0] id, input logic [31:0] addr, input int len);
        int   n;
        logic hs;
        aw_req  = '{id: id, addr: addr, len: 8'(len), burst: 2'b01};
        awvalid = 1'b1;
        n = 0;
        do begin
            @(posedge s_axi_aclk);
            n++;
            if (n > TIMEOUT) fail_timeout("AW handshake");
        end while (!awready);
        #2 awvalid = 1'b0;
        bready = $urandom % 2;  // random B stalls
        n = 0;
        do begin
            @(posedge s_axi_aclk);
            n++;
            if (n > TIMEOUT) fail_timeout("B handshake");
            hs = bvalid && bready;
            if (!hs) #2 bready = $urandom % 2;
        end while (!hs);
        check_val("bid", id, bid);
        #2 bready = 1'b0;
    endtask

    task automatic do_read(input logic [3:0] id, input logic [31:0] addr, input int len,
                           input logic wrap);
        int          n;
        int          k;
        logic [31:0] exp_beat;
        ar_req  = '{id: id, addr: addr, len: 8'(len), burst: wrap ? 2'b10 : 2'b01};
        arvalid = 1'b1;
        n = 0;
        do begin
            @(posedge s_axi_aclk);
            n++;
            if (n > TIMEOUT) fail_timeout("AR handshake");
        end while (!arready);
        #2 arvalid = 1'b0;
        rready = $urandom % 2;
        k = 0;
        n = 0;
        while (k <= len) begin
            @(posedge s_axi_aclk);
            n++;
            if (n > TIMEOUT) fail_timeout("R beat");
            if (rvalid && rready) begin
                exp_beat = {ref_mem[half_addr(addr, len, wrap, 2 * k + 1)],
                            ref_mem[half_addr(addr, len, wrap, 2 * k)]};
                check_val("rdata", exp_beat, rdata);
                check_val("rlast", k == len, rlast);
                check_val("rid", id, rid);
                k++;
            end
            #2 rready = $urandom % 2;
        end
        rready = 1'b0;
        if (rvalid) begin
            mismatch_errs++;
            $display("read in %s returned more beats than requested", test_name);
        end
    endtask

    initial begin
        logic [31:0] waddr;
        logic [31:0] raddr;
        int          wlen;
        int          rlen;
        logic [31:0] tie_waddr [4];
        int          tie_wlen [4];
        logic [31:0] tie_raddr [4];
        int          tie_rlen [4];
        void'($urandom(74));
        s_axi_aclk = 1'b0;
        s_axi_aresetn = 1'b0;
        aw_req = '0;
        ar_req = '0;
        awvalid = 1'b0;
        arvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        rready = 1'b0;
        for (int i = 0; i < 2**REF_AW; i++) ref_mem[i] = 16'(i * 32'h2F1B) ^ 16'hC35A;
        repeat (8) @(posedge s_axi_aclk);
        #2 s_axi_aresetn = 1'b1;

        test_name = "rr_tie";
        for (int i = 0; i < 4; i++) begin
            tie_waddr[i] = $urandom & 32'h3FC;
            tie_wlen[i]  = $urandom % 4;  // all four bursts fit the write buffer at once
            tie_raddr[i] = 32'h800 | ($urandom & 32'h3FC);  // kept apart from the writes
            tie_rlen[i]  = $urandom % 8;
            send_wdata(tie_waddr[i], tie_wlen[i]);
        end
        // both sides re-request at once, so every choice but the last is a tie
        fork
            for (int i = 0; i < 4; i++) begin
                send_awb(4'($urandom), tie_waddr[i], tie_wlen[i]);
            end
            for (int i = 0; i < 4; i++) begin
                do_read(4'($urandom), tie_raddr[i], tie_rlen[i], 1'b0);
            end
        join
        check_val("command count", 8, kind_q.size());
        foreach (kind_q[i]) check_val("wr_not_rd", (i % 2) == 0, kind_q[i]);

        test_name = "incr_readback";
        repeat (6) begin
            waddr = $urandom & 32'hF000_0FFC;  // upper bits fall outside the memory window
            wlen  = $urandom % 8;
            send_wdata(waddr, wlen);
            send_awb(4'($urandom), waddr, wlen);
            do_read(4'($urandom), waddr, wlen, 1'b0);
        end

        test_name = "wrap_read";
        repeat (4) begin
            rlen  = (2 << ($urandom % 3)) - 1;
            raddr = ($urandom & 32'h0FFC) & ~((rlen + 1) * 4 - 1);
            raddr = raddr + (1 + $urandom % rlen) * 4;  // start inside the boundary
            do_read(4'($urandom), raddr, rlen, 1'b1);
        end

        repeat (4) @(posedge s_axi_aclk);
        finish_run();
    end

endmodule

`default_nettype wire

// File: tb.f
hw/hbmc_pkg.sv
hw/xfer_arbiter.sv
hw/wr_resp_tracker.sv
hw/wdata_splitter.sv
hw/rdata_assembler.sv
hw/axi_hbmc_top.sv
verif/hb_mem_model.sv
verif/tb_axi_hbmc.sv

// File: Bender.yml
package:
  name: axi_hbmc

sources:
  - hw/hbmc_pkg.sv
  - hw/xfer_arbiter.sv
  - hw/wr_resp_tracker.sv
  - hw/wdata_splitter.sv
  - hw/rdata_assembler.sv
  - hw/axi_hbmc_top.sv
  - target: test
    files:
      - verif/hb_mem_model.sv
      - verif/tb_axi_hbmc.sv
